// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "FAIL: simulation ended without a result"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/cache_array.sv ====
`include "cache_consts.svh"

module cache_array (
	input logic clk,
	input logic reset,
	cache_array_if.array arr
);

	localparam int LINES = 1 << `CACHE_INDEX_W;
	localparam int WORDS = 1 << (`CACHE_INDEX_W + `CACHE_WORD_W);

	cache_pkg::tag_t tag_mem [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	cache_pkg::data_t data_mem [WORDS];

	logic [`CACHE_INDEX_W+`CACHE_WORD_W-1:0] word_addr;
	logic fill_last; // last fill beat of a line
	logic word_we;

	assign word_addr = {arr.index, arr.word};
	assign fill_last = arr.write && !arr.comp && (arr.word == 2'd3);

	// compare write only lands on a hit, fills always land
	assign word_we = arr.write && (!arr.comp || arr.hit);

	//////////////////////////////
	// lookup
	//////////////////////////////
	assign arr.victim_tag = tag_mem[arr.index];
	assign arr.hit = valid_q[arr.index] && (tag_mem[arr.index] == arr.tag);
	assign arr.dirty = valid_q[arr.index] && dirty_q[arr.index];
	assign arr.rdata = data_mem[word_addr];

	//////////////////////////////
	// state bits
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (fill_last) begin
				valid_q[arr.index] <= 1'b1;
				dirty_q[arr.index] <= 1'b0; // fresh line is clean
			end else if (arr.write && arr.comp && arr.hit) begin
				dirty_q[arr.index] <= 1'b1;
			end
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (fill_last)
			tag_mem[arr.index] <= arr.tag;
		if (word_we)
			data_mem[word_addr] <= arr.wdata;
	end

	// controller must hold off compare writes on a miss
	a_comp_write_hit: assert property (@(posedge clk) disable iff (reset)
		(arr.comp && arr.write) |-> arr.hit);

endmodule

// ==== hdl/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address and data word
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

// address split: tag | index | word | byte
`define CACHE_TAG_W 5
`define CACHE_INDEX_W 8
`define CACHE_WORD_W 2

// backing memory is word addressed
`define MEM_ADDR_W 15

`endif

// ==== hdl/cache_controller.sv ====
`include "cache_consts.svh"

module cache_controller (
	input logic clk,
	input logic reset,
	input logic rd,
	input logic wr,
	input logic [`CACHE_ADDR_W-1:0] addr,
	input cache_pkg::data_t data_in,
	output logic done,
	output logic resp_valid,
	output cache_pkg::data_t data_out,
	output logic hit,
	cache_array_if.controller arr,
	mem_if.master mem
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t next_state;

	logic accept;
	logic in_comp;
	logic missed; // first compare of this request missed

	// latched request
	logic op_wr;
	logic [`CACHE_ADDR_W-1:0] addr_q;
	cache_pkg::data_t data_q;

	cache_pkg::tag_t req_tag;
	cache_pkg::index_t req_index;
	cache_pkg::word_sel_t req_word;
	cache_pkg::word_sel_t beat_word;

	assign done = (state == cache_pkg::IDLE);
	assign accept = done && (rd ^ wr);
	assign in_comp = (state == cache_pkg::COMP_READ) || (state == cache_pkg::COMP_WRITE);

	assign req_tag = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index = addr_q[`CACHE_WORD_W+1 +: `CACHE_INDEX_W];
	assign req_word = addr_q[1 +: `CACHE_WORD_W]; // bit 0 ignored

	// word of the current memory beat
	always_comb begin
		case (state)
			cache_pkg::WB1, cache_pkg::FILL1: beat_word = 2'd1;
			cache_pkg::WB2, cache_pkg::FILL2: beat_word = 2'd2;
			cache_pkg::WB3, cache_pkg::FILL3: beat_word = 2'd3;
			default: beat_word = 2'd0;
		endcase
	end

	assign arr.index = req_index;
	assign arr.tag = req_tag;

	//////////////////////////////
	// next state and outputs
	//////////////////////////////
	always_comb begin
		next_state = state;
		arr.comp = 1'b0;
		arr.write = 1'b0;
		arr.word = req_word;
		arr.wdata = data_q;
		mem.rd = 1'b0;
		mem.wr = 1'b0;
		mem.addr = {req_tag, req_index, beat_word};
		mem.wdata = arr.rdata;

		case (state)
			cache_pkg::IDLE: begin
				if (accept)
					next_state = wr ? cache_pkg::COMP_WRITE : cache_pkg::COMP_READ;
			end
			cache_pkg::COMP_READ, cache_pkg::COMP_WRITE: begin
				arr.comp = 1'b1;
				arr.write = op_wr && arr.hit; // no compare write on a miss
				if (arr.hit)
					next_state = cache_pkg::IDLE;
				else if (arr.dirty)
					next_state = cache_pkg::WB0;
				else
					next_state = cache_pkg::FILL0;
			end
			cache_pkg::WB0, cache_pkg::WB1, cache_pkg::WB2, cache_pkg::WB3: begin
				arr.word = beat_word;
				mem.wr = 1'b1;
				mem.addr = {arr.victim_tag, req_index, beat_word}; // victim line
				if (!mem.stall)
					next_state = cache_pkg::ctrl_state_t'(state + 4'd1); // WB3 -> FILL0
			end
			cache_pkg::FILL0, cache_pkg::FILL1, cache_pkg::FILL2, cache_pkg::FILL3: begin
				arr.word = beat_word;
				arr.wdata = mem.rdata;
				arr.write = !mem.stall; // word lands at end of beat
				mem.rd = 1'b1;
				if (!mem.stall) begin
					if (state == cache_pkg::FILL3)
						next_state = op_wr ? cache_pkg::COMP_WRITE : cache_pkg::COMP_READ;
					else
						next_state = cache_pkg::ctrl_state_t'(state + 4'd1);
				end
			end
			default: next_state = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::IDLE;
			resp_valid <= 1'b0;
			missed <= 1'b0;
		end else begin
			state <= next_state;
			resp_valid <= in_comp && arr.hit;
			if (accept)
				missed <= 1'b0;
			else if (in_comp && !arr.hit)
				missed <= 1'b1;
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (accept) begin
			op_wr <= wr;
			addr_q <= addr;
			data_q <= data_in;
		end
		if (in_comp && arr.hit) begin
			data_out <= arr.rdata;
			hit <= !missed;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_mem_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem.rd && mem.wr));

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {cache_pkg::IDLE, cache_pkg::COMP_READ, cache_pkg::COMP_WRITE,
			[cache_pkg::WB0:cache_pkg::FILL3]});

	// both strobes while idle is dropped
	a_no_dual_accept: assert property (@(posedge clk) disable iff (reset)
		(done && rd && wr) |=> state == cache_pkg::IDLE);

endmodule

// ==== hdl/cache_ifs.sv ====
`include "cache_consts.svh"

//////////////////////////////
// controller <-> cache array
//////////////////////////////
interface cache_array_if;
	cache_pkg::index_t index;
	cache_pkg::tag_t tag;
	cache_pkg::word_sel_t word;
	logic comp; // compare access
	logic write; // write strobe
	cache_pkg::data_t wdata;

	logic hit;
	logic dirty;
	cache_pkg::tag_t victim_tag; // tag stored at index
	cache_pkg::data_t rdata;

	modport controller (
		output index, tag, word, comp, write, wdata,
		input hit, dirty, victim_tag, rdata
	);

	modport array (
		input index, tag, word, comp, write, wdata,
		output hit, dirty, victim_tag, rdata
	);
endinterface

//////////////////////////////
// controller <-> main memory
//////////////////////////////
interface mem_if;
	logic [`MEM_ADDR_W-1:0] addr; // word address
	cache_pkg::data_t wdata;
	logic rd;
	logic wr;
	cache_pkg::data_t rdata;
	logic stall;

	modport master (output addr, wdata, rd, wr, input rdata, stall);

	modport memory (input addr, wdata, rd, wr, output rdata, stall);
endinterface

// ==== hdl/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

	// address fields
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_WORD_W-1:0] word_sel_t;

	typedef logic [`CACHE_DATA_W-1:0] data_t;

	// WB* and FILL* must stay consecutive, the controller steps through them by +1
	typedef enum logic [3:0] {
		IDLE,
		COMP_READ,
		COMP_WRITE,
		WB0,
		WB1,
		WB2,
		WB3,
		FILL0,
		FILL1,
		FILL2,
		FILL3
	} ctrl_state_t;

endpackage

// ==== hdl/cache_top.sv ====
`include "cache_consts.svh"

module cache_top #(
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic reset,
	input logic rd,
	input logic wr,
	input logic [`CACHE_ADDR_W-1:0] addr,
	input logic [`CACHE_DATA_W-1:0] data_in,
	output logic done,
	output logic resp_valid,
	output logic [`CACHE_DATA_W-1:0] data_out,
	output logic hit
);

	cache_array_if arr_if ();
	mem_if mem_bus ();

	cache_controller ctrl_i (
		.clk (clk),
		.reset (reset),
		.rd (rd),
		.wr (wr),
		.addr (addr),
		.data_in (data_in),
		.done (done),
		.resp_valid (resp_valid),
		.data_out (data_out),
		.hit (hit),
		.arr (arr_if.controller),
		.mem (mem_bus.master)
	);

	cache_array array_i (
		.clk (clk),
		.reset (reset),
		.arr (arr_if.array)
	);

	// backing store, not reset
	mem_model #(
		.MEM_LATENCY (MEM_LATENCY)
	) mem_i (
		.clk (clk),
		.mem (mem_bus.memory)
	);

endmodule

// ==== hdl/mem_model.sv ====
`include "cache_consts.svh"

module mem_model #(
	parameter int MEM_LATENCY = 3 // cycles per word, at least 1
) (
	input logic clk,
	mem_if.memory mem
);

	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
	localparam int DEPTH = 1 << `MEM_ADDR_W;

	cache_pkg::data_t store [DEPTH];

	logic [CNT_W-1:0] beat_cnt; // cycles into current beat
	logic busy;
	logic last;

	assign busy = mem.rd || mem.wr;
	assign last = (beat_cnt == CNT_W'(MEM_LATENCY - 1));

	// stall through the beat, drop it in the final cycle
	assign mem.stall = busy && !last;
	assign mem.rdata = store[mem.addr];

	//////////////////////////////
	// beat timing
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (busy && !last)
			beat_cnt <= beat_cnt + 1'b1;
		else
			beat_cnt <= '0; // idle or beat done
	end

	// write completes on the last edge of the beat
	always_ff @(posedge clk) begin
		if (mem.wr && last)
			store[mem.addr] <= mem.wdata;
	end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_ifs.sv
hdl/cache_array.sv
hdl/mem_model.sv
hdl/cache_controller.sv
hdl/cache_top.sv
verification/tb_clock_gen.sv
verification/cache_tb.sv

// ==== verification/cache_tb.sv ====
`include "cache_consts.svh"

module cache_tb;

	localparam int MEM_LAT = 3;
	localparam int DIRTY_LAT = 8 * MEM_LAT + 3;
	localparam int RESP_CAP = DIRTY_LAT + 10;
	localparam int N_OPS = 240;
	localparam longint TIMEOUT = longint'(N_OPS) * DIRTY_LAT * 100 * 2;
	localparam int LINES = 1 << `CACHE_INDEX_W;
	localparam int MEM_WORDS = 1 << `MEM_ADDR_W;

	logic clk;
	logic por_reset;
	logic soft_reset;
	logic dut_reset;
	logic rd;
	logic wr;
	logic [`CACHE_ADDR_W-1:0] addr;
	logic [`CACHE_DATA_W-1:0] data_in;
	logic done;
	logic resp_valid;
	logic [`CACHE_DATA_W-1:0] data_out;
	logic hit;

	// shadow tags and memory image
	bit sh_valid [LINES];
	bit sh_dirty [LINES];
	logic [4:0] sh_tag [LINES];
	logic [15:0] ref_mem [MEM_WORDS];
	bit ref_known [MEM_WORDS];

	// expected responses, issue order
	bit exp_hit_q [$];
	logic [15:0] exp_data_q [$];
	bit exp_known_q [$];
	int exp_lat_q [$];
	int acc_cyc_q [$];
	string name_q [$];

	int cycle_cnt = 0;
	int resp_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;

	assign dut_reset = por_reset | soft_reset;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) clk_gen_i (.clk(clk), .reset(por_reset));

	cache_top #(.MEM_LATENCY(MEM_LAT)) cache_top_i (
		.clk(clk), .reset(dut_reset), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
		.done(done), .resp_valid(resp_valid), .data_out(data_out), .hit(hit)
	);

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic logic [15:0] make_addr(input logic [4:0] t, input logic [7:0] idx,
			input logic [1:0] w);
		return {t, idx, w, 1'b0};
	endfunction

	function automatic void predict(input bit is_wr, input logic [15:0] a, input logic [15:0] d,
			output bit e_hit, output logic [15:0] e_data, output bit e_known, output int e_lat);
		logic [4:0] t;
		logic [7:0] idx;
		logic [14:0] wa;
		t = a[15:11];
		idx = a[10:3];
		wa = a[15:1];
		e_hit = sh_valid[idx] && (sh_tag[idx] == t);
		if (e_hit)
			e_lat = 2;
		else if (sh_valid[idx] && sh_dirty[idx])
			e_lat = DIRTY_LAT; // write-back first
		else
			e_lat = 4 * MEM_LAT + 3;
		if (!e_hit) begin
			sh_valid[idx] = 1'b1;
			sh_tag[idx] = t;
			sh_dirty[idx] = 1'b0;
		end
		if (is_wr) begin
			sh_dirty[idx] = 1'b1;
			ref_mem[wa] = d;
			ref_known[wa] = 1'b1;
		end
		e_data = ref_mem[wa];
		e_known = !is_wr && ref_known[wa];
	endfunction

	// dirty lines are lost on reset
	function automatic void reset_shadow();
		for (int i = 0; i < LINES; i++) begin
			if (sh_valid[i] && sh_dirty[i])
				for (int w = 0; w < 4; w++)
					ref_known[{sh_tag[i], i[7:0], w[1:0]}] = 1'b0;
			sh_valid[i] = 1'b0;
			sh_dirty[i] = 1'b0;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// response compare
	always @(negedge clk) begin
		string n;
		int lat;
		bit e_hit;
		logic [15:0] e_data;
		bit e_known;
		int e_lat;
		if (!dut_reset && resp_valid) begin
			if (name_q.size() == 0) begin
				errors++;
				$display("response arrived with no request outstanding");
			end else begin
				n = name_q.pop_front();
				lat = cycle_cnt - acc_cyc_q.pop_front() + 1;
				e_hit = exp_hit_q.pop_front();
				e_data = exp_data_q.pop_front();
				e_known = exp_known_q.pop_front();
				e_lat = exp_lat_q.pop_front();
				check_value({n, " hit"}, 32'(e_hit), 32'(hit));
				check_value({n, " latency"}, e_lat, lat);
				if (e_known)
					check_value({n, " data"}, 32'(e_data), 32'(data_out));
			end
			resp_count++;
		end
	end

	//////////////////////////////
	// driver
	//////////////////////////////
	task automatic wait_idle();
		@(negedge clk);
		while (!done)
			@(negedge clk);
	endtask

	task automatic start_request(input bit is_wr, input logic [15:0] a, input logic [15:0] d,
			input string name);
		bit e_hit;
		logic [15:0] e_data;
		bit e_known;
		int e_lat;
		wait_idle();
		predict(is_wr, a, d, e_hit, e_data, e_known, e_lat);
		exp_hit_q.push_back(e_hit);
		exp_data_q.push_back(e_data);
		exp_known_q.push_back(e_known);
		exp_lat_q.push_back(e_lat);
		acc_cyc_q.push_back(cycle_cnt + 2); // accepted two edges on
		name_q.push_back(name);
		@(posedge clk);
		rd <= !is_wr;
		wr <= is_wr;
		addr <= a;
		data_in <= d;
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
	endtask

	task automatic wait_response(input int seen, input string name);
		int waited;
		waited = 0;
		while (resp_count == seen && waited < RESP_CAP) begin
			@(posedge clk);
			waited++;
		end
		if (resp_count == seen) begin
			errors++;
			$display("no response to %s after %0d cycles", name, waited);
		end
	endtask

	task automatic issue_request(input bit is_wr, input logic [15:0] a, input logic [15:0] d,
			input string name);
		int seen;
		seen = resp_count;
		start_request(is_wr, a, d, name);
		wait_response(seen, name);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err_base)
			tests_failed++;
		$display("test %s: %s, %0d errors", name,
			(errors == test_err_base) ? "ok" : "FAILED", errors - test_err_base);
		test_err_base = errors;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	initial begin
		logic [15:0] a_addr;
		logic [15:0] b_addr;
		logic [15:0] pool [32];
		bit written [32];
		logic [4:0] rand_tags [3];
		int slot;
		int seen;
		int busy_cycles;
		bit do_wr;

		void'($urandom(32'h2f68_2fba));
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		soft_reset = 1'b0;
		do @(negedge clk); while (dut_reset);

		a_addr = make_addr(5'h02, 8'h10, 2'd1);
		issue_request(1'b1, a_addr, 16'h1234, "write_read write");
		issue_request(1'b0, a_addr, 16'h0, "write_read read");
		end_test("write_read");

		for (int w = 0; w < 4; w++)
			issue_request(1'b1, make_addr(5'h04, 8'h20, 2'(w)), 16'h2000 + 16'(w),
				$sformatf("line_fill write %0d", w));
		for (int w = 0; w < 4; w++)
			issue_request(1'b0, make_addr(5'h04, 8'h20, 2'(w)), 16'h0,
				$sformatf("line_fill read %0d", w));
		end_test("line_fill");

		a_addr = make_addr(5'h03, 8'h30, 2'd2);
		b_addr = make_addr(5'h09, 8'h30, 2'd2); // same index, other tag
		issue_request(1'b1, a_addr, 16'ha0a0, "dirty_evict write a");
		issue_request(1'b1, b_addr, 16'hb0b0, "dirty_evict write b");
		issue_request(1'b0, a_addr, 16'h0, "dirty_evict read a");
		end_test("dirty_evict");

		// 32 addresses, 4 indices x 3 tags
		rand_tags = '{5'h01, 5'h0a, 5'h13};
		for (int k = 0; k < 32; k++) begin
			pool[k] = make_addr(rand_tags[k % 3], 8'h40 + 8'((k / 3) % 4), 2'(k / 12));
			written[k] = 1'b0;
		end
		for (int n = 0; n < 200; n++) begin
			slot = $urandom % 32;
			do_wr = ($urandom % 2 == 1) || !written[slot];
			written[slot] = 1'b1;
			issue_request(do_wr, pool[slot], 16'($urandom), $sformatf("random_mix op %0d", n));
		end
		end_test("random_mix");

		// both strobes while idle
		wait_idle();
		seen = resp_count;
		@(posedge clk);
		rd <= 1'b1;
		wr <= 1'b1;
		addr <= pool[0];
		data_in <= 16'hdead;
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		busy_cycles = 0;
		repeat (10) begin
			@(negedge clk);
			if (!done)
				busy_cycles++;
		end
		@(posedge clk);
		check_value("ignored dual strobe responses", 0, resp_count - seen);
		check_value("ignored dual strobe busy cycles", 0, busy_cycles);

		// request while busy
		seen = resp_count;
		a_addr = make_addr(5'h07, 8'h50, 2'd1);
		start_request(1'b1, a_addr, 16'h5b5b, "ignored busy write");
		repeat (3) @(posedge clk);
		rd <= 1'b1;
		addr <= pool[1];
		@(posedge clk);
		rd <= 1'b0;
		wait_response(seen, "ignored busy write");
		repeat (RESP_CAP) @(posedge clk);
		check_value("ignored busy responses", 1, resp_count - seen);
		end_test("ignored");

		// clean copy of a in the cache, then reset
		a_addr = make_addr(5'h05, 8'h60, 2'd3);
		b_addr = make_addr(5'h0c, 8'h60, 2'd3);
		issue_request(1'b1, a_addr, 16'h6a6a, "reset write a");
		issue_request(1'b1, b_addr, 16'h6b6b, "reset write b");
		issue_request(1'b0, a_addr, 16'h0, "reset read a");

		// reset lands in the middle of a line fill
		wait_idle();
		@(posedge clk);
		wr <= 1'b1;
		addr <= make_addr(5'h0e, 8'h70, 2'd0);
		data_in <= 16'h7c7c;
		@(posedge clk);
		wr <= 1'b0;
		repeat (4) @(posedge clk);
		soft_reset <= 1'b1;
		repeat (2) @(posedge clk);
		soft_reset <= 1'b0;
		reset_shadow();
		@(negedge clk);
		check_value("reset done", 1, 32'(done));
		check_value("reset resp_valid", 0, 32'(resp_valid));
		issue_request(1'b0, a_addr, 16'h0, "reset read a after reset");
		end_test("reset");

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("timeout: run did not finish within %0d time units", TIMEOUT);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// power-on reset, released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule
